// ==== Makefile ====
# Verilator build and run of the serial link testbench

TOP := tb_serial_link

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -j 0 -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== bench/tb_clk_gen.sv ====
// Testbench clock and reset generator
// Free-running clock, synchronous reset held for a fixed number of cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    // Release between clock edges
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/tb_serial_link.sv ====
// Serial link testbench
// Loops the lanes back, drives APB and the tx stream, checks the rx stream
`timescale 1ns/1ps
`default_nettype none
`include "serial_link_cfg.svh"

module tb_serial_link
  import serial_link_pkg::*;
();

  localparam int CLK_PERIOD_NS   = 10;
  localparam int BURST_LEN       = 16;
  localparam int MAX_DIV         = 9;
  localparam int TOTAL_FLITS     = 1 + 2 * BURST_LEN + 6;
  localparam int FLIT_CYCLES     = `SL_BEATS * MAX_DIV * 2 + 20;
  localparam int QUIET_CYCLES    = 2 * `SL_BEATS * MAX_DIV;
  localparam int SETTLE_CYCLES   = 8;
  localparam int MARGIN_CYCLES   = 3000;
  localparam int WATCHDOG_CYCLES = TOTAL_FLITS * `SL_BEATS * MAX_DIV * 2 + MARGIN_CYCLES;

  logic     clk;
  logic     reset;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  flit_t    tx_flit;
  logic     tx_valid;
  logic     tx_ready;
  flit_t    rx_flit;
  logic     rx_valid;
  logic     rx_ready;
  beat_t    ddr_loop;
  logic     ddr_clk_loop;

  integer      seed = 32'h3544;
  flit_t       exp_q[$];
  flit_t       head_flit;
  int          rx_seen;
  int          pass_count;
  int          fail_count;
  int          edge_count;
  int          valid_count;
  logic        ddr_clk_prev;
  logic        rx_iso_model;
  logic        model_full;
  logic [7:0]  exp_count;
  logic        err;
  logic [31:0] rdata;
  int          edges_before;
  int          valid_before;
  logic        ready_seen;

  tb_clk_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (5)
  ) u_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  // Forwarded clock and lanes come straight back in
  serial_link UUT (
    .clk_i      (clk),
    .reset_i    (reset),
    .apb_req_i  (apb_req),
    .tx_flit_i  (tx_flit),
    .tx_valid_i (tx_valid),
    .rx_ready_i (rx_ready),
    .ddr_i      (ddr_loop),
    .ddr_clk_i  (ddr_clk_loop),
    .apb_rsp_o  (apb_rsp),
    .tx_ready_o (tx_ready),
    .rx_flit_o  (rx_flit),
    .rx_valid_o (rx_valid),
    .ddr_o      (ddr_loop),
    .ddr_clk_o  (ddr_clk_loop)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // A sent flit arrives unless rx is isolated or its register stays occupied
  function automatic logic expected_rx(input logic rx_iso, input logic held,
                                       input logic ready);
    expected_rx = !rx_iso && (!held || ready);
  endfunction

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      fail_count++;
    end else begin
      $display("PASS %s", name);
      pass_count++;
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp,
                           input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      fail_count++;
    end else begin
      $display("PASS %s", name);
      pass_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      fail_count++;
    end else begin
      $display("PASS %s", name);
      pass_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus and stream drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic slverr);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    slverr = apb_rsp.pslverr;
    if (apb_rsp.pready !== 1'b1) begin
      $display("ERROR: APB write to %h needed a wait state", addr);
      fail_count++;
    end
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic slverr);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(posedge clk);
    data   = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    if (apb_rsp.pready !== 1'b1) begin
      $display("ERROR: APB read from %h needed a wait state", addr);
      fail_count++;
    end
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic set_ctrl(input logic link_en, input logic tx_iso, input logic rx_iso);
    logic slverr;
    apb_write(`SL_ADDR_CTRL, {29'd0, rx_iso, tx_iso, link_en}, slverr);
    rx_iso_model = rx_iso;
  endtask

  task automatic set_div(input logic [7:0] div);
    logic slverr;
    apb_write(`SL_ADDR_CLK_DIV, 32'(div), slverr);
  endtask

  // STATUS holds tx_busy at bit 8, which is low once the link is idle
  task automatic check_status(input string name);
    logic [31:0] data;
    logic        slverr;
    apb_read(`SL_ADDR_STATUS, data, slverr);
    check_reg(name, 32'(exp_count), data);
  endtask

  task automatic send_flit(input flit_t flit);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    @(negedge clk);
    tx_flit  = flit;
    tx_valid = 1'b1;
    while (!taken && waited < FLIT_CYCLES) begin
      @(posedge clk);
      taken = tx_ready;
      waited++;
    end
    if (!taken) begin
      $display("ERROR: flit %h was not accepted within %0d cycles", flit, FLIT_CYCLES);
      fail_count++;
    end else if (expected_rx(rx_iso_model, model_full, rx_ready)) begin
      exp_q.push_back(flit);
      exp_count = exp_count + 8'd1;
      if (!rx_ready) begin
        model_full = 1'b1;
      end
    end
  endtask

  task automatic idle_tx();
    @(negedge clk);
    tx_valid = 1'b0;
  endtask

  task automatic wait_drained(input string what);
    int waited;
    int limit;
    waited = 0;
    limit  = (exp_q.size() + 1) * FLIT_CYCLES;
    while (exp_q.size() != 0 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: %s timed out with %0d flits never received", what, exp_q.size());
      fail_count++;
      exp_q.delete();
    end
  endtask

  task automatic wait_edges(input int target);
    int waited;
    waited = 0;
    while (edge_count < target && waited < 4 * FLIT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (edge_count < target) begin
      $display("ERROR: forwarded clock stopped after %0d of %0d edges", edge_count, target);
      fail_count++;
    end
    repeat (SETTLE_CYCLES) @(negedge clk);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      edge_count   <= 0;
      valid_count  <= 0;
      ddr_clk_prev <= 1'b0;
    end else begin
      if (ddr_clk_loop != ddr_clk_prev) begin
        edge_count <= edge_count + 1;
      end
      if (rx_valid) begin
        valid_count <= valid_count + 1;
      end
      ddr_clk_prev <= ddr_clk_loop;
    end
  end

  // Every rx handshake must match the oldest expected flit
  always @(posedge clk) begin
    if (!reset && rx_valid && rx_ready) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: flit %h was received while none was expected", rx_flit);
        fail_count++;
      end else begin
        head_flit = exp_q.pop_front();
        check_flit($sformatf("rx flit %0d", rx_seen), head_flit, rx_flit);
      end
      rx_seen++;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
             WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    apb_req      = '0;
    tx_flit      = '0;
    tx_valid     = 1'b0;
    rx_ready     = 1'b1;
    rx_seen      = 0;
    pass_count   = 0;
    fail_count   = 0;
    rx_iso_model = 1'b0;
    model_full   = 1'b0;
    exp_count    = 8'd0;
    wait (reset === 1'b0);
    @(negedge clk);
    check_bit("tx_ready_o after reset", 1'b1, tx_ready);
    check_bit("ddr_clk_o after reset", 1'b0, ddr_clk_loop);
    check_reg("ddr_o after reset", 32'd0, 32'(ddr_loop));
    check_bit("rx_valid_o after reset", 1'b0, rx_valid);
    check_bit("pslverr after reset", 1'b0, apb_rsp.pslverr);

    // Registers
    apb_read(`SL_ADDR_CTRL, rdata, err);
    check_reg("CTRL reset value", 32'd0, rdata);
    check_bit("pslverr on mapped address", 1'b0, err);
    apb_read(`SL_ADDR_CLK_DIV, rdata, err);
    check_reg("CLK_DIV reset value", 32'd8, rdata);
    check_status("STATUS reset value");
    apb_write(`SL_ADDR_CTRL, 32'h5, err);
    apb_read(`SL_ADDR_CTRL, rdata, err);
    check_reg("CTRL write and read", 32'h5, rdata);
    set_ctrl(1'b0, 1'b0, 1'b0);
    set_div(8'd2);
    apb_read(`SL_ADDR_CLK_DIV, rdata, err);
    check_reg("CLK_DIV clamped to minimum", 32'd4, rdata);
    apb_read(8'h0C, rdata, err);
    check_bit("pslverr on unmapped address", 1'b1, err);

    // Single flit loopback
    set_ctrl(1'b1, 1'b0, 1'b0);
    set_div(8'd4);
    edges_before = edge_count;
    send_flit($random(seed));
    idle_tx();
    wait_drained("single flit loopback");
    check_reg("ddr_clk_o edges per flit", 32'd8, 32'(edge_count - edges_before));
    check_bit("ddr_clk_o low after flit", 1'b0, ddr_clk_loop);

    // Back-to-back bursts at two dividers
    set_div(8'd4);
    for (int i = 0; i < BURST_LEN; i++) begin
      send_flit($random(seed));
    end
    idle_tx();
    wait_drained("burst at divider 4");
    set_div(8'd9);
    for (int i = 0; i < BURST_LEN; i++) begin
      send_flit($random(seed));
    end
    idle_tx();
    wait_drained("burst at divider 9");
    check_status("STATUS rx_count after bursts");

    // tx isolation blocks the stream
    set_ctrl(1'b1, 1'b1, 1'b0);
    edges_before = edge_count;
    ready_seen   = 1'b0;
    @(negedge clk);
    tx_flit  = $random(seed);
    tx_valid = 1'b1;
    repeat (QUIET_CYCLES) begin
      @(posedge clk);
      if (tx_ready) begin
        ready_seen = 1'b1;
      end
    end
    idle_tx();
    check_bit("tx_ready_o while tx isolated", 1'b0, ready_seen);
    check_reg("ddr_clk_o edges while tx isolated", 32'd0, 32'(edge_count - edges_before));

    // Disabled link holds the flit until enabled again
    set_ctrl(1'b0, 1'b0, 1'b0);
    edges_before = edge_count;
    send_flit($random(seed));
    idle_tx();
    repeat (QUIET_CYCLES) @(negedge clk);
    check_reg("ddr_clk_o edges while disabled", 32'd0, 32'(edge_count - edges_before));
    set_ctrl(1'b1, 1'b0, 1'b0);
    wait_drained("flit held while disabled");

    // rx isolation discards arriving flits
    set_ctrl(1'b1, 1'b0, 1'b1);
    edges_before = edge_count;
    valid_before = valid_count;
    send_flit($random(seed));
    send_flit($random(seed));
    idle_tx();
    wait_edges(edges_before + 2 * `SL_BEATS);
    check_reg("rx_valid_o cycles while rx isolated", 32'd0,
              32'(valid_count - valid_before));
    check_status("STATUS rx_count after rx isolation");
    set_ctrl(1'b1, 1'b0, 1'b0);

    // Back-pressure keeps the first flit and loses the second
    @(negedge clk);
    rx_ready     = 1'b0;
    edges_before = edge_count;
    send_flit($random(seed));
    send_flit($random(seed));
    idle_tx();
    wait_edges(edges_before + 2 * `SL_BEATS);
    check_bit("rx_valid_o held under back-pressure", 1'b1, rx_valid);
    if (exp_q.size() != 0) begin
      check_flit("rx_flit_o held under back-pressure", exp_q[0], rx_flit);
    end
    @(negedge clk);
    rx_ready   = 1'b1;
    model_full = 1'b0;
    wait_drained("back-pressure release");
    repeat (SETTLE_CYCLES) @(negedge clk);
    check_status("STATUS rx_count after back-pressure");

    $display("Checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
src/serial_link_pkg.sv
src/serial_link_regs.sv
src/serial_link_clk_div.sv
src/serial_link_tx_fsm.sv
src/serial_link_rx_deser.sv
src/serial_link_stream_reg.sv
src/serial_link.sv
bench/tb_clk_gen.sv
bench/tb_serial_link.sv

// ==== include/serial_link_cfg.svh ====
// Serial link configuration constants
// Lane and flit sizes, divider range and the APB register map
`ifndef SERIAL_LINK_CFG_SVH
`define SERIAL_LINK_CFG_SVH

// Physical lanes and flit framing
`define SL_NUM_LANES 4
`define SL_FLIT_WIDTH 32
`define SL_BEATS (`SL_FLIT_WIDTH / `SL_NUM_LANES)

// Half-period divider in clk_i cycles
`define SL_DIV_WIDTH 8
`define SL_MIN_DIV 4
`define SL_DEFAULT_DIV 8

// APB register map
`define SL_ADDR_WIDTH 8
`define SL_APB_DATA_WIDTH 32
`define SL_ADDR_CTRL 8'h00
`define SL_ADDR_CLK_DIV 8'h04
`define SL_ADDR_STATUS 8'h08

`endif

// ==== src/serial_link.sv ====
// Serial link top level
// Registers, half-period timer, transmit FSM and receive deserializer
`timescale 1ns/1ps
`default_nettype none

module serial_link
  import serial_link_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  apb_req_t apb_req_i,
  input  flit_t    tx_flit_i,
  input  logic     tx_valid_i,
  input  logic     rx_ready_i,
  input  beat_t    ddr_i,
  input  logic     ddr_clk_i,
  output apb_rsp_t apb_rsp_o,
  output logic     tx_ready_o,
  output flit_t    rx_flit_o,
  output logic     rx_valid_o,
  output beat_t    ddr_o,
  output logic     ddr_clk_o
);

  link_cfg_t cfg;
  flit_t     tx_flit;
  logic      tx_valid;
  logic      tx_ready;
  logic      run;
  logic      tick;
  logic      tx_busy;
  flit_t     deser_flit;
  logic      deser_valid;
  logic      rx_accept;

  serial_link_regs u_regs (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .apb_req_i   (apb_req_i),
    .tx_busy_i   (tx_busy),
    .rx_accept_i (rx_accept),
    .apb_rsp_o   (apb_rsp_o),
    .cfg_o       (cfg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////////////////////

  serial_link_stream_reg u_tx_reg (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .isolate_i   (cfg.tx_isolate),
    .in_flit_i   (tx_flit_i),
    .in_valid_i  (tx_valid_i),
    .out_ready_i (tx_ready),
    .in_ready_o  (tx_ready_o),
    .out_flit_o  (tx_flit),
    .out_valid_o (tx_valid),
    .accept_o    ()
  );

  serial_link_clk_div u_clk_div (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .run_i     (run),
    .clk_div_i (cfg.clk_div),
    .tick_o    (tick)
  );

  serial_link_tx_fsm u_tx_fsm (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cfg_i        (cfg),
    .flit_i       (tx_flit),
    .flit_valid_i (tx_valid),
    .tick_i       (tick),
    .flit_ready_o (tx_ready),
    .run_o        (run),
    .busy_o       (tx_busy),
    .ddr_o        (ddr_o),
    .ddr_clk_o    (ddr_clk_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////////////////////

  serial_link_rx_deser u_rx_deser (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cfg_i        (cfg),
    .ddr_i        (ddr_i),
    .ddr_clk_i    (ddr_clk_i),
    .flit_o       (deser_flit),
    .flit_valid_o (deser_valid)
  );

  // With no flow control back to the sender a refused flit is lost
  serial_link_stream_reg u_rx_reg (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .isolate_i   (cfg.rx_isolate),
    .in_flit_i   (deser_flit),
    .in_valid_i  (deser_valid),
    .out_ready_i (rx_ready_i),
    .in_ready_o  (),
    .out_flit_o  (rx_flit_o),
    .out_valid_o (rx_valid_o),
    .accept_o    (rx_accept)
  );

endmodule

`default_nettype wire

// ==== src/serial_link_clk_div.sv ====
// Half-period timer for the forwarded clock
// Pulses tick once every clk_div cycles while run is high
`timescale 1ns/1ps
`default_nettype none

module serial_link_clk_div
  import serial_link_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic run_i,
  input  div_t clk_div_i,
  output logic tick_o
);

  div_t count_q;
  div_t last_count;

  assign last_count = clk_div_i - 1'b1;

  // Tick on the final count of each half period
  assign tick_o = run_i && (count_q == last_count);

  always_ff @(posedge clk_i) begin
    if (reset_i || !run_i) begin
      // Start every run from a fresh half period
      count_q <= '0;
    end else if (count_q == last_count) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/serial_link_pkg.sv ====
// Shared types of the serial link
// Flits, lane beats, APB request/response, configuration and status
`default_nettype none
`include "serial_link_cfg.svh"

package serial_link_pkg;

  typedef logic [`SL_FLIT_WIDTH-1:0] flit_t;
  typedef logic [`SL_NUM_LANES-1:0] beat_t;
  typedef logic [`SL_DIV_WIDTH-1:0] div_t;

  typedef struct packed {
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [`SL_ADDR_WIDTH-1:0]      paddr;
    logic [`SL_APB_DATA_WIDTH-1:0]  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                           pready;
    logic                           pslverr;
    logic [`SL_APB_DATA_WIDTH-1:0]  prdata;
  } apb_rsp_t;

  // Register fields seen by the link
  typedef struct packed {
    logic link_en;
    logic tx_isolate;
    logic rx_isolate;
    div_t clk_div;
  } link_cfg_t;

  // STATUS holds tx_busy at bit 8 and rx_count in bits 7:0
  typedef struct packed {
    logic       tx_busy;
    logic [7:0] rx_count;
  } link_status_t;

endpackage

`default_nettype wire

// ==== src/serial_link_regs.sv ====
// Serial link register block
// APB slave holding CTRL and CLK_DIV and reporting tx busy and received flits in STATUS
`timescale 1ns/1ps
`default_nettype none
`include "serial_link_cfg.svh"

module serial_link_regs
  import serial_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  apb_req_t  apb_req_i,
  input  logic      tx_busy_i,
  input  logic      rx_accept_i,
  output apb_rsp_t  apb_rsp_o,
  output link_cfg_t cfg_o
);

  link_cfg_t    cfg_q;
  logic [7:0]   rx_count_q;
  link_status_t status;
  logic         access;
  logic         write;
  logic         hit_ctrl;
  logic         hit_div;
  logic         hit_status;
  div_t         div_wdata;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign access     = apb_req_i.psel && apb_req_i.penable;
  assign write      = access && apb_req_i.pwrite;
  assign hit_ctrl   = apb_req_i.paddr == `SL_ADDR_CTRL;
  assign hit_div    = apb_req_i.paddr == `SL_ADDR_CLK_DIV;
  assign hit_status = apb_req_i.paddr == `SL_ADDR_STATUS;

  // Keep the half period long enough for the receive synchronizer
  assign div_wdata = (apb_req_i.pwdata[`SL_DIV_WIDTH-1:0] < div_t'(`SL_MIN_DIV)) ?
                     div_t'(`SL_MIN_DIV) : apb_req_i.pwdata[`SL_DIV_WIDTH-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cfg_q <= '{link_en: 1'b0, tx_isolate: 1'b0, rx_isolate: 1'b0,
                 clk_div: div_t'(`SL_DEFAULT_DIV)};
    end else if (write && hit_ctrl) begin
      cfg_q.link_en    <= apb_req_i.pwdata[0];
      cfg_q.tx_isolate <= apb_req_i.pwdata[1];
      cfg_q.rx_isolate <= apb_req_i.pwdata[2];
    end else if (write && hit_div) begin
      cfg_q.clk_div <= div_wdata;
    end
  end

  // Count of received flits wraps at 256
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_count_q <= '0;
    end else if (rx_accept_i) begin
      rx_count_q <= rx_count_q + 8'd1;
    end
  end

  assign status = '{tx_busy: tx_busy_i, rx_count: rx_count_q};

  ////////////////////////////////////////////////////////////////////////////
  // Read path without wait states
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    apb_rsp_o         = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = access && !(hit_ctrl || hit_div || hit_status);
    if (access && !apb_req_i.pwrite) begin
      if (hit_ctrl) begin
        apb_rsp_o.prdata = 32'({cfg_q.rx_isolate, cfg_q.tx_isolate, cfg_q.link_en});
      end else if (hit_div) begin
        apb_rsp_o.prdata = 32'(cfg_q.clk_div);
      end else if (hit_status) begin
        apb_rsp_o.prdata = 32'(status);
      end
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// ==== src/serial_link_rx_deser.sv ====
// Receive deserializer of the serial link
// Synchronizes the forwarded clock and lanes, then rebuilds flits beat by beat
`timescale 1ns/1ps
`default_nettype none
`include "serial_link_cfg.svh"

module serial_link_rx_deser
  import serial_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  link_cfg_t cfg_i,
  input  beat_t     ddr_i,
  input  logic      ddr_clk_i,
  output flit_t     flit_o,
  output logic      flit_valid_o
);

  localparam int unsigned BeatIdxW = $clog2(`SL_BEATS);

  // Clock and lanes stay aligned through the synchronizer
  typedef struct packed {
    logic  clk;
    beat_t beat;
  } ddr_sample_t;

  ddr_sample_t         sync_q1;
  ddr_sample_t         sync_q2;
  ddr_sample_t         prev_q;
  logic [BeatIdxW-1:0] beat_idx_q;
  logic                valid_q;
  logic                edge_det;
  flit_t               flit_q;

  assign edge_det = cfg_i.link_en && (sync_q2.clk != prev_q.clk);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync_q1    <= '0;
      sync_q2    <= '0;
      prev_q     <= '0;
      beat_idx_q <= '0;
      valid_q    <= 1'b0;
    end else begin
      sync_q1    <= '{clk: ddr_clk_i, beat: ddr_i};
      sync_q2    <= sync_q1;
      prev_q     <= sync_q2;
      valid_q    <= 1'b0;
      if (!cfg_i.link_en) begin
        beat_idx_q <= '0;
      end else if (edge_det) begin
        // Index wraps to zero after the last beat
        beat_idx_q <= beat_idx_q + 1'b1;
        valid_q    <= beat_idx_q == BeatIdxW'(`SL_BEATS - 1);
      end
    end
  end

  // The sender changes data with the edge, so take the beat from before it
  always_ff @(posedge clk_i) begin
    if (edge_det) begin
      flit_q[beat_idx_q*`SL_NUM_LANES +: `SL_NUM_LANES] <= prev_q.beat;
    end
  end

  assign flit_o       = flit_q;
  assign flit_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== src/serial_link_stream_reg.sv ====
// One-entry valid/ready register for flits
// Refuses input while isolated and flags every accepted flit
`timescale 1ns/1ps
`default_nettype none

module serial_link_stream_reg
  import serial_link_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  isolate_i,
  input  flit_t in_flit_i,
  input  logic  in_valid_i,
  input  logic  out_ready_i,
  output logic  in_ready_o,
  output flit_t out_flit_o,
  output logic  out_valid_o,
  output logic  accept_o
);

  logic  full_q;
  flit_t data_q;

  // Accept when empty or when the held flit leaves this cycle
  assign in_ready_o  = !isolate_i && (!full_q || out_ready_i);
  assign accept_o    = in_valid_i && in_ready_o;
  assign out_valid_o = full_q;
  assign out_flit_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q <= 1'b0;
    end else if (accept_o) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      data_q <= in_flit_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/serial_link_tx_fsm.sv ====
// Transmit FSM of the serial link
// Loads a flit, drives its beats on the lanes and toggles the forwarded clock
`timescale 1ns/1ps
`default_nettype none
`include "serial_link_cfg.svh"

module serial_link_tx_fsm
  import serial_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  link_cfg_t cfg_i,
  input  flit_t     flit_i,
  input  logic      flit_valid_i,
  input  logic      tick_i,
  output logic      flit_ready_o,
  output logic      run_o,
  output logic      busy_o,
  output beat_t     ddr_o,
  output logic      ddr_clk_o
);

  localparam int unsigned BeatIdxW = $clog2(`SL_BEATS);

  typedef enum logic {
    StIdle,
    StShift
  } state_e;

  state_e              state_q;
  logic [BeatIdxW-1:0] beat_idx_q;
  logic                clk_q;
  flit_t               shift_q;
  logic                load;
  logic                last_beat;

  assign flit_ready_o = (state_q == StIdle) && cfg_i.link_en && !cfg_i.tx_isolate;
  assign load         = flit_valid_i && flit_ready_o;
  assign run_o        = state_q == StShift;
  assign busy_o       = run_o || load;
  assign last_beat    = beat_idx_q == BeatIdxW'(`SL_BEATS - 1);

  // Lowest beat goes out first and lanes idle low
  assign ddr_o     = run_o ? beat_t'(shift_q[`SL_NUM_LANES-1:0]) : '0;
  assign ddr_clk_o = clk_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= StIdle;
      beat_idx_q <= '0;
      clk_q      <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          if (load) begin
            state_q    <= StShift;
            beat_idx_q <= '0;
          end
        end
        StShift: begin
          if (tick_i) begin
            clk_q <= !clk_q;
            // Eighth edge brings the clock back low
            if (last_beat) begin
              state_q    <= StIdle;
              beat_idx_q <= '0;
            end else begin
              beat_idx_q <= beat_idx_q + 1'b1;
            end
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  // Data moves to the next beat together with the clock edge
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= flit_i;
    end else if (run_o && tick_i && !last_beat) begin
      shift_q <= shift_q >> `SL_NUM_LANES;
    end
  end

endmodule

`default_nettype wire
